// File: Bender.yml
package:
  name: stream_gen

export_include_dirs:
  - logic

sources:
  - target: any(rtl, test)
    include_dirs:
      - logic
    files:
      - logic/stream_gen_pkg.sv
      - logic/burst_sequencer.sv
      - logic/axis_out_slice.sv
      - logic/stream_gen_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - sim/stream_gen_chk.sv
      - sim/stream_gen_tb.sv

// File: filelist.f
+incdir+logic
logic/stream_gen_pkg.sv
logic/burst_sequencer.sv
logic/axis_out_slice.sv
logic/stream_gen_top.sv
sim/stream_gen_chk.sv
sim/stream_gen_tb.sv

// File: logic/axis_out_slice.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_gen_defs.svh"

module axis_out_slice (
  input  logic                          M_AXIS_ACLK,
  input  logic                          M_AXIS_ARESETN,
  input  stream_gen_pkg::axis_beat_t    in_beat,
  input  logic                          in_valid,
  output logic                          in_ready,
  output logic [`STREAM_DATA_WIDTH-1:0] m_axis_tdata,
  output logic                          m_axis_tlast,
  output logic                          m_axis_tvalid,
  input  logic                          m_axis_tready
);

  stream_gen_pkg::axis_beat_t main_beat;
  stream_gen_pkg::axis_beat_t skid_beat;
  logic                       main_valid;
  logic                       skid_valid;
  logic                       main_load;
  logic                       in_fire;

  // Upstream sees ready as long as the skid entry is free
  assign in_ready  = ~skid_valid;
  assign in_fire   = in_valid & in_ready;
  assign main_load = ~main_valid | m_axis_tready;  // Main register empty or draining

  assign m_axis_tdata  = main_beat.data;
  assign m_axis_tlast  = main_beat.last;
  assign m_axis_tvalid = main_valid;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      main_valid <= skid_valid | in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;  // Output stalled so the new beat parks here
    end
  end

  // The skid entry always holds the older beat, so it moves up first
  always_ff @(posedge M_AXIS_ACLK) begin
    if (main_load) begin
      main_beat <= skid_valid ? skid_beat : in_beat;
    end
    if (!main_load && in_fire) begin
      skid_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

// File: logic/burst_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_gen_defs.svh"

module burst_sequencer (
  input  logic                       M_AXIS_ACLK,
  input  logic                       M_AXIS_ARESETN,
  input  stream_gen_pkg::burst_cmd_t cmd,
  input  logic                       cmd_req,
  output logic                       cmd_ack,
  output stream_gen_pkg::axis_beat_t seq_beat,
  output logic                       seq_valid,
  input  logic                       seq_ready
);

  localparam int unsigned W      = `STREAM_DATA_WIDTH;
  localparam int unsigned CNT_W  = $clog2(`STREAM_START_COUNT + 1);
  localparam int unsigned LEN_W  = stream_gen_pkg::LEN_W;

  typedef enum logic [1:0] {
    st_wait_start,
    st_idle,
    st_run,
    st_release
  } state_e;

  state_e                     state;
  logic [CNT_W-1:0]           start_cnt;
  stream_gen_pkg::pattern_e   mode_r;    // Pattern latched at acceptance
  logic [LEN_W-1:0]           len_m1_r;  // Final beat index latched at acceptance
  logic [W-1:0]               word;
  logic [W-1:0]               next_word;
  logic [LEN_W-1:0]           beat_idx;
  logic                       accept;
  logic                       beat_move;

  assign accept    = (state == st_idle) && cmd_req;
  assign beat_move = seq_valid && seq_ready;

  assign seq_beat.data = word;
  assign seq_beat.last = (beat_idx == len_m1_r);

  // Successor of the current word under the latched pattern
  always_comb begin
    if (mode_r == stream_gen_pkg::pat_lfsr) begin
      next_word = {word[W-2:0], 1'b0} ^ ({W{word[W-1]}} & W'(`STREAM_LFSR_POLY));
    end else begin
      next_word = word + 1'b1;
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state     <= st_wait_start;
      start_cnt <= '0;
      cmd_ack   <= 1'b0;
      seq_valid <= 1'b0;
    end else begin
      if (cmd_ack && !cmd_req) begin
        cmd_ack <= 1'b0;  // Host has dropped its request
      end
      case (state)
        st_wait_start: begin
          if (start_cnt == CNT_W'(`STREAM_START_COUNT - 1)) begin
            state <= st_idle;
          end else begin
            start_cnt <= start_cnt + 1'b1;
          end
        end
        st_idle: begin
          if (accept) begin
            cmd_ack <= 1'b1;
            state   <= st_run;
          end
        end
        st_run: begin
          if (!seq_valid) begin
            seq_valid <= 1'b1;  // First beat goes out one cycle after the ack
          end else if (beat_move && seq_beat.last) begin
            seq_valid <= 1'b0;
            state     <= st_release;
          end
        end
        st_release: begin
          // Previous handshake must be complete before another command
          if (!cmd_ack) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_wait_start;
        end
      endcase
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (accept) begin
      mode_r   <= cmd.mode;
      len_m1_r <= cmd.len_m1;
      word     <= cmd.start;
      beat_idx <= '0;
    end else if (beat_move) begin
      word     <= next_word;
      beat_idx <= beat_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/stream_gen_defs.svh
`ifndef STREAM_GEN_DEFS_SVH
`define STREAM_GEN_DEFS_SVH

// Width of one stream word in bits
`define STREAM_DATA_WIDTH 32

// Longest burst a single command can ask for
`define STREAM_MAX_BURST 16

// Clock cycles after reset before the first command is taken
`define STREAM_START_COUNT 32

// Feedback constant applied when the top bit shifts out
`define STREAM_LFSR_POLY 32'h04C11DB7

`endif

// File: logic/stream_gen_pkg.sv
`default_nettype none

`include "stream_gen_defs.svh"

package stream_gen_pkg;

  localparam int unsigned LEN_W = $clog2(`STREAM_MAX_BURST);  // Bits of len_m1

  typedef enum logic {
    pat_count = 1'b0,  // Word is start plus beat index
    pat_lfsr  = 1'b1   // Word follows the shift and feedback rule
  } pattern_e;

  // Burst command from the host
  typedef struct packed {
    pattern_e                      mode;
    logic [LEN_W-1:0]              len_m1;  // Burst length minus one
    logic [`STREAM_DATA_WIDTH-1:0] start;
  } burst_cmd_t;

  // One stream beat
  typedef struct packed {
    logic [`STREAM_DATA_WIDTH-1:0] data;
    logic                          last;
  } axis_beat_t;

endpackage

`default_nettype wire

// File: logic/stream_gen_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_gen_defs.svh"

module stream_gen_top (
  input  logic                          M_AXIS_ACLK,
  input  logic                          M_AXIS_ARESETN,
  input  stream_gen_pkg::burst_cmd_t    cmd,
  input  logic                          cmd_req,
  output logic                          cmd_ack,
  output logic [`STREAM_DATA_WIDTH-1:0] m_axis_tdata,
  output logic                          m_axis_tlast,
  output logic                          m_axis_tvalid,
  input  logic                          m_axis_tready
);

  stream_gen_pkg::axis_beat_t seq_beat;
  logic                       seq_valid;
  logic                       seq_ready;

  burst_sequencer u_sequencer (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd            (cmd),
    .cmd_req        (cmd_req),
    .cmd_ack        (cmd_ack),
    .seq_beat       (seq_beat),
    .seq_valid      (seq_valid),
    .seq_ready      (seq_ready)
  );

  // Output slice decouples stream back-pressure from beat generation
  axis_out_slice u_out_slice (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .in_beat        (seq_beat),
    .in_valid       (seq_valid),
    .in_ready       (seq_ready),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tready  (m_axis_tready)
  );

endmodule

`default_nettype wire

// File: sim/stream_gen_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_gen_defs.svh"

module stream_gen_chk (
  input logic                          M_AXIS_ACLK,
  input logic                          M_AXIS_ARESETN,
  input logic                          cmd_req,
  input logic                          cmd_ack,
  input logic [`STREAM_DATA_WIDTH-1:0] m_axis_tdata,
  input logic                          m_axis_tlast,
  input logic                          m_axis_tvalid,
  input logic                          m_axis_tready
);

  localparam int unsigned CNT_W = $clog2(`STREAM_START_COUNT + 1);

  logic [CNT_W-1:0] since_reset;      // Cycles since reset release, saturating
  int               violations = 0;   // Count of failed assertions

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      since_reset <= '0;
    end else if (since_reset != CNT_W'(`STREAM_START_COUNT)) begin
      since_reset <= since_reset + 1'b1;
    end
  end

  tvalid_low_after_reset: assert property (@(posedge M_AXIS_ACLK)
      !M_AXIS_ARESETN |=> !m_axis_tvalid)
    else begin
      $error("m_axis_tvalid was high in the cycle after reset");
      violations++;
    end

  // A stalled beat must be held exactly as it was offered
  stream_stable_on_stall: assert property (@(posedge M_AXIS_ACLK)
      disable iff (!M_AXIS_ARESETN)
      m_axis_tvalid && !m_axis_tready |=>
        m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
      $error("Stream output changed while stalled by m_axis_tready");
      violations++;
    end

  ack_held_while_req: assert property (@(posedge M_AXIS_ACLK)
      disable iff (!M_AXIS_ARESETN)
      cmd_ack && cmd_req |=> cmd_ack)
    else begin
      $error("cmd_ack fell while cmd_req was still high");
      violations++;
    end

  no_ack_in_start_delay: assert property (@(posedge M_AXIS_ACLK)
      disable iff (!M_AXIS_ARESETN)
      (since_reset < CNT_W'(`STREAM_START_COUNT)) |-> !cmd_ack)
    else begin
      $error("cmd_ack rose inside the start-up delay");
      violations++;
    end

endmodule

bind stream_gen_top stream_gen_chk u_protocol_chk (
  .M_AXIS_ACLK    (M_AXIS_ACLK),
  .M_AXIS_ARESETN (M_AXIS_ARESETN),
  .cmd_req        (cmd_req),
  .cmd_ack        (cmd_ack),
  .m_axis_tdata   (m_axis_tdata),
  .m_axis_tlast   (m_axis_tlast),
  .m_axis_tvalid  (m_axis_tvalid),
  .m_axis_tready  (m_axis_tready)
);

`default_nettype wire

// File: sim/stream_gen_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_gen_defs.svh"

module stream_gen_tb;

  localparam int unsigned W              = `STREAM_DATA_WIDTH;
  localparam int          TIMEOUT_CYCLES = 4000;  // 120 beats at three cycles each stays far below
  localparam logic [31:0] SEED           = 32'h5c9ddb5a;

  logic                       M_AXIS_ACLK = 1'b0;
  logic                       M_AXIS_ARESETN;
  stream_gen_pkg::burst_cmd_t cmd;
  logic                       cmd_req;
  logic                       cmd_ack;
  logic [W-1:0]               m_axis_tdata;
  logic                       m_axis_tlast;
  logic                       m_axis_tvalid;
  logic                       m_axis_tready;

  stream_gen_pkg::axis_beat_t exp_q[$];
  stream_gen_pkg::axis_beat_t exp_beat;
  logic [31:0]                rng_state     = SEED;
  logic                       ready_random  = 1'b0;
  int                         burst_lens[3] = '{1, 5, 16};
  int                         cycle         = 0;
  int                         xfer_count    = 0;
  int                         err_count     = 0;
  int                         err_mark      = 0;
  int                         tests_passed  = 0;
  int                         tests_failed  = 0;
  int                         ack_cycles;
  int                         xfer_base;
  int                         first_cycle;

  stream_gen_top DUT (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd            (cmd),
    .cmd_req        (cmd_req),
    .cmd_ack        (cmd_ack),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tready  (m_axis_tready)
  );

  always #10 M_AXIS_ACLK = ~M_AXIS_ACLK;  // 20 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected beat idx of a burst, straight from the pattern rule
  function automatic stream_gen_pkg::axis_beat_t expected_beat(
    input stream_gen_pkg::burst_cmd_t c,
    input int                         idx
  );
    stream_gen_pkg::axis_beat_t b;
    logic [W-1:0]               w;
    w = c.start;
    if (c.mode == stream_gen_pkg::pat_count) begin
      w = c.start + idx;
    end else begin
      for (int k = 0; k < idx; k++) begin
        if (w[W-1]) begin
          w = (w << 1) ^ `STREAM_LFSR_POLY;
        end else begin
          w = w << 1;
        end
      end
    end
    b.data = w;
    b.last = (idx == int'(c.len_m1));
    return b;
  endfunction

  function automatic int total_errors();
    return err_count + DUT.u_protocol_chk.violations;
  endfunction

  // Four-phase handshake, called on a falling edge and returning on one
  task automatic send_command(
    input  stream_gen_pkg::pattern_e mode,
    input  int                       len,
    input  logic [W-1:0]             start,
    output int                       cycles_to_ack
  );
    stream_gen_pkg::burst_cmd_t c;
    int                         len_m1;
    len_m1   = len - 1;
    c.mode   = mode;
    c.len_m1 = len_m1[stream_gen_pkg::LEN_W-1:0];
    c.start  = start;
    for (int i = 0; i < len; i++) begin
      exp_q.push_back(expected_beat(c, i));
    end
    cmd           = c;
    cmd_req       = 1'b1;
    cycles_to_ack = 0;
    while (!cmd_ack) begin
      @(negedge M_AXIS_ACLK);
      cycles_to_ack++;
    end
    cmd_req = 1'b0;
    while (cmd_ack) begin
      @(negedge M_AXIS_ACLK);
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge M_AXIS_ACLK);
    end
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = total_errors() - err_mark;
    if (errs == 0) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errs);
    end
    err_mark = total_errors();
  endtask

  always @(negedge M_AXIS_ACLK) begin
    if (ready_random) begin
      rng_state = xorshift32(rng_state);
      m_axis_tready <= rng_state[0];
    end else begin
      m_axis_tready <= 1'b1;
    end
  end

  always @(posedge M_AXIS_ACLK) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d beats still expected", cycle, exp_q.size());
      $display("Some tests failed");
      $finish;
    end
  end

  // Every transfer is checked against the head of the expected queue
  always @(posedge M_AXIS_ACLK) begin
    if (M_AXIS_ARESETN && m_axis_tvalid && m_axis_tready) begin
      xfer_count++;
      assert (exp_q.size() != 0) else begin
        err_count++;
        $display("Beat %h came out of the stream when no beat was expected", m_axis_tdata);
      end
      if (exp_q.size() != 0) begin
        exp_beat = exp_q.pop_front();
        assert (m_axis_tdata == exp_beat.data) else begin
          err_count++;
          $display("error: m_axis_tdata = %h, expected %h (beat %0d)",
                   m_axis_tdata, exp_beat.data, xfer_count);
        end
        assert (m_axis_tlast == exp_beat.last) else begin
          err_count++;
          $display("error: m_axis_tlast = %h, expected %h (beat %0d)",
                   m_axis_tlast, exp_beat.last, xfer_count);
        end
      end
    end
  end

  initial begin
    M_AXIS_ARESETN = 1'b0;
    cmd            = '0;
    cmd_req        = 1'b0;
    m_axis_tready  = 1'b0;
    repeat (10) @(negedge M_AXIS_ACLK);
    M_AXIS_ARESETN = 1'b1;

    // Request goes up in the first cycle after reset
    send_command(stream_gen_pkg::pat_count, 4, 32'h0000_1000, ack_cycles);
    assert (ack_cycles > `STREAM_START_COUNT) else begin
      err_count++;
      $display("cmd_ack rose %0d cycles after reset, inside the start-up delay of %0d cycles",
               ack_cycles, `STREAM_START_COUNT);
    end
    wait_drained();
    report_test("test 1 start-up delay");

    xfer_base = xfer_count;
    send_command(stream_gen_pkg::pat_count, 16, 32'hFFFF_FFF8, ack_cycles);
    while (xfer_count < xfer_base + 1) begin
      @(negedge M_AXIS_ACLK);
    end
    first_cycle = cycle;
    while (xfer_count < xfer_base + 16) begin
      @(negedge M_AXIS_ACLK);
    end
    assert (cycle - first_cycle == 15) else begin
      err_count++;
      $display("Counting burst took %0d cycles after its first beat, not one beat per cycle",
               cycle - first_cycle);
    end
    wait_drained();
    report_test("test 2 counting burst");

    send_command(stream_gen_pkg::pat_lfsr, 8, 32'hC0DE_1234, ack_cycles);
    wait_drained();
    report_test("test 3 LFSR burst");

    ready_random <= 1'b1;  // Takes effect from the next falling edge
    foreach (burst_lens[k]) begin
      send_command(stream_gen_pkg::pat_count, burst_lens[k], 32'h7FFF_FFFD + k, ack_cycles);
      send_command(stream_gen_pkg::pat_lfsr, burst_lens[k], 32'hB504_F333 ^ k, ack_cycles);
    end
    wait_drained();
    ready_random <= 1'b0;
    report_test("test 4 random back-pressure");

    send_command(stream_gen_pkg::pat_count, 16, 32'h0000_0000, ack_cycles);
    send_command(stream_gen_pkg::pat_lfsr, 16, 32'hFFFF_FFFF, ack_cycles);
    send_command(stream_gen_pkg::pat_count, 16, 32'h1234_5670, ack_cycles);
    wait_drained();
    report_test("test 5 back-to-back commands");

    repeat (20) @(negedge M_AXIS_ACLK);  // Any stray beat shows up here
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
